// ==== common/ksBus_consts.svh ====
////////////////////////////////////////////////////////////////////////////
// Bus words use [0:35] numbering, so bit 0 is the MSB and bit 35 the LSB
// The memory index is taken from the low KS_MEM_AW address bits only
////////////////////////////////////////////////////////////////////////////

`ifndef KSBUS_CONSTS_SVH
`define KSBUS_CONSTS_SVH

// Bus word
`define KS_WIDTH      36

// Address control bits
`define KS_WRITE_BIT  3              // Set for a write cycle
`define KS_IO_BIT     4              // Set for I/O space, clear for memory

// Adapter number field in I/O addresses, 0 is the console
`define KS_UBA_MSB    14
`define KS_UBA_LSB    17

// Register select inside an adapter
`define KS_REG_MSB    34
`define KS_REG_LSB    35

// Memory size
`define KS_MEM_AW     10
`define KS_MEM_DEPTH  (1 << `KS_MEM_AW)

`endif

// ==== common/ksBusPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared bus types, word width comes from ksBus_consts.svh
////////////////////////////////////////////////////////////////////////////

`include "ksBus_consts.svh"

package ksBusPkg;

   // One bus word, big-endian numbering as on the KS10 backplane
   typedef logic [0:`KS_WIDTH-1] ksWord_t;

   // Bus cycle type, decoded from the address write bit
   typedef enum logic
   {
      opRead,
      opWrite
   } busOp_t;

   // Memory controller states
   typedef enum logic [1:0]
   {
      memIdle,                       // Waiting for a memory cycle
      memWait,                       // Single wait state
      memAck,                        // Ack high, write committed here
      memRecover                     // Lets the master drop its request
   } memState_t;

   // Adapter DMA engine states
   typedef enum logic [1:0]
   {
      ubaIdle,
      ubaDma,                        // DMA write request on the bus
      ubaDone                        // One cycle, busy clears
   } ubaState_t;

endpackage

// ==== arb/busArb.sv ====
////////////////////////////////////////////////////////////////////////////
// Purely combinational, a request is routed in the same cycle it appears
// Priority is fixed, an adapter master can reach memory only
////////////////////////////////////////////////////////////////////////////

module busArb
   import ksBusPkg::*;
(
   // CPU master
   input  logic    cpuReq,           // CPU bus request
   output logic    cpuAck,           // CPU bus acknowledge
   input  ksWord_t cpuAddr,          // CPU address
   input  ksWord_t cpuWdata,         // CPU write data
   output ksWord_t cpuRdata,         // CPU read data
   // Console, master and slave
   input  logic    cslReqIn,         // Console bus request
   output logic    cslAckOut,        // Console bus acknowledge
   input  ksWord_t cslAddr,          // Console address
   input  ksWord_t cslWdata,         // Console write data
   output ksWord_t cslRdata,         // Console read data, or CPU write data
   output logic    cslReqOut,        // Request to the console slave
   input  logic    cslAckIn,         // Console slave acknowledge
   input  ksWord_t cslSlaveData,     // Console slave read data
   // Unibus adapter 1
   input  logic    uba1Req,          // DMA request
   output logic    uba1Ack,          // DMA acknowledge
   input  ksWord_t uba1Addr,
   input  ksWord_t uba1Wdata,
   input  logic    uba1AckIn,        // Slave acknowledge
   input  ksWord_t uba1Rdata,        // Slave read data
   // Unibus adapter 3
   input  logic    uba3Req,
   output logic    uba3Ack,
   input  ksWord_t uba3Addr,
   input  ksWord_t uba3Wdata,
   input  logic    uba3AckIn,
   input  ksWord_t uba3Rdata,
   // Adapter slave side
   output logic    ubaReq,           // Request to both adapters
   output ksWord_t ubaData,          // Write data, or DMA read data
   // Memory
   output logic    memReq,
   input  logic    memAck,
   input  ksWord_t memRdata,
   output ksWord_t memData,
   // Shared address
   output ksWord_t arbAddr
);

   always_comb
   begin
      // Nothing granted, data parked at zero
      cpuAck    = 1'b0;
      cpuRdata  = '0;
      cslAckOut = 1'b0;
      cslRdata  = '0;
      cslReqOut = 1'b0;
      uba1Ack   = 1'b0;
      uba3Ack   = 1'b0;
      ubaReq    = 1'b0;
      ubaData   = '0;
      memReq    = 1'b0;
      memData   = '0;
      arbAddr   = '0;

      /////////////////////////////////////////////////////////////////////////
      // Console, highest priority
      /////////////////////////////////////////////////////////////////////////
      if (cslReqIn)
      begin
         memReq  = 1'b1;                     // Memory or adapters
         ubaReq  = 1'b1;
         arbAddr = cslAddr;
         memData = cslWdata;
         ubaData = cslWdata;
         if (memAck)
         begin
            cslAckOut = 1'b1;
            cslRdata  = memRdata;
         end
         else if (uba1AckIn)
         begin
            cslAckOut = 1'b1;
            cslRdata  = uba1Rdata;
         end
         else if (uba3AckIn)
         begin
            cslAckOut = 1'b1;
            cslRdata  = uba3Rdata;
         end
      end

      /////////////////////////////////////////////////////////////////////////
      // Adapter DMA, memory only
      /////////////////////////////////////////////////////////////////////////
      else if (uba1Req)
      begin
         memReq  = 1'b1;
         arbAddr = uba1Addr;
         memData = uba1Wdata;
         if (memAck)
         begin
            uba1Ack = 1'b1;
            ubaData = memRdata;              // DMA read data path
         end
      end
      else if (uba3Req)
      begin
         memReq  = 1'b1;
         arbAddr = uba3Addr;
         memData = uba3Wdata;
         if (memAck)
         begin
            uba3Ack = 1'b1;
            ubaData = memRdata;
         end
      end

      /////////////////////////////////////////////////////////////////////////
      // CPU, lowest priority, can also reach the console
      /////////////////////////////////////////////////////////////////////////
      else if (cpuReq)
      begin
         memReq    = 1'b1;
         ubaReq    = 1'b1;
         cslReqOut = 1'b1;
         arbAddr   = cpuAddr;
         memData   = cpuWdata;
         ubaData   = cpuWdata;
         cslRdata  = cpuWdata;               // Write data into console space
         if (memAck)
         begin
            cpuAck   = 1'b1;
            cpuRdata = memRdata;
         end
         else if (uba1AckIn)
         begin
            cpuAck   = 1'b1;
            cpuRdata = uba1Rdata;
         end
         else if (uba3AckIn)
         begin
            cpuAck   = 1'b1;
            cpuRdata = uba3Rdata;
         end
         else if (cslAckIn)
         begin
            cpuAck   = 1'b1;
            cpuRdata = cslSlaveData;
         end
      end
   end

endmodule

// ==== mem/memCtrl.sv ====
////////////////////////////////////////////////////////////////////////////
// One wait state, ack one cycle, then one recovery cycle before resampling
// Only the low KS_MEM_AW address bits are decoded, upper bits alias
////////////////////////////////////////////////////////////////////////////

`include "ksBus_consts.svh"

module memCtrl
   import ksBusPkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    memReq,           // Request from the arbiter
   input  ksWord_t arbAddr,          // Bus address
   input  ksWord_t memData,          // Write data
   output logic    memAck,           // Acknowledge, one cycle
   output ksWord_t memRdata          // Read data, valid with memAck
);

   memState_t             state;
   ksWord_t               mem [0:`KS_MEM_DEPTH-1] = '{default: '0};  // Powers up clear
   logic [0:`KS_MEM_AW-1] memIdx;
   logic                  memSel;    // Memory space cycle on the bus
   busOp_t                op;

   assign memSel = memReq && !arbAddr[`KS_IO_BIT];         // I/O cycles ignored
   assign memIdx = arbAddr[`KS_WIDTH-`KS_MEM_AW:`KS_WIDTH-1];
   assign op     = arbAddr[`KS_WRITE_BIT] ? opWrite : opRead;

   ////////////////////////////////////////////////////////////////////////////
   // Cycle FSM
   ////////////////////////////////////////////////////////////////////////////

   // Idle, wait, ack and recover for every memory space cycle
   always_ff @(posedge clk)
   begin
      if (reset)
         state <= memIdle;
      else
      begin
         case (state)
            memIdle:
               if (memSel)
                  state <= memWait;
            memWait:
               if (memSel)
                  state <= ksBusPkg::memAck;
               else
                  state <= memIdle;          // Request withdrawn, drop it
            ksBusPkg::memAck:
               state <= memRecover;
            memRecover:
               state <= memIdle;             // Master has released by now
            default:
               state <= memIdle;
         endcase
      end
   end

   assign memAck = (state == ksBusPkg::memAck);

   ////////////////////////////////////////////////////////////////////////////
   // Array access
   ////////////////////////////////////////////////////////////////////////////

   // Read data captured on the way into the ack state
   always_ff @(posedge clk)
   begin
      if ((state == memWait) && memSel)
         memRdata <= mem[memIdx];
   end

   // Write lands at the end of the ack cycle
   always @(posedge clk)
   begin
      if ((state == ksBusPkg::memAck) && memSel && (op == opWrite))
         mem[memIdx] <= memData;
   end

endmodule

// ==== uba/ubaBridge.sv ====
////////////////////////////////////////////////////////////////////////////
// Registers: 0 data, 1 DMA address, 2 status with busy in bit 35
// A DMA address write while busy is ignored, one DMA word per start
////////////////////////////////////////////////////////////////////////////

`include "ksBus_consts.svh"

module ubaBridge
   import ksBusPkg::*;
#(
   parameter int ubaNum = 1          // Adapter number in the I/O field
)
(
   input  logic    clk,
   input  logic    reset,
   input  logic    ubaReq,           // Slave request from the arbiter
   input  ksWord_t arbAddr,
   input  ksWord_t ubaData,          // Slave write data
   output logic    slvAck,           // Slave acknowledge
   output ksWord_t slvRdata,         // Slave read data
   output logic    dmaReq,           // DMA master request
   output ksWord_t dmaAddr,
   output ksWord_t dmaWdata,
   input  logic    dmaAck            // DMA acknowledge from the arbiter
);

   localparam int              ubaW   = `KS_UBA_LSB - `KS_UBA_MSB + 1;
   localparam logic [0:ubaW-1] ubaSel = ubaW'(ubaNum);

   ksWord_t    dataReg;
   ksWord_t    dmaAddrReg;
   ksWord_t    statusWord;
   logic       busy;
   logic       slvIdle;              // Dead cycle after each ack
   logic       hit;
   logic       wrStrobe;
   logic [0:1] regSel;
   busOp_t     op;
   ubaState_t  state;

   assign hit = ubaReq && arbAddr[`KS_IO_BIT]
                && (arbAddr[`KS_UBA_MSB:`KS_UBA_LSB] == ubaSel);
   assign regSel     = arbAddr[`KS_REG_MSB:`KS_REG_LSB];
   assign op         = arbAddr[`KS_WRITE_BIT] ? opWrite : opRead;
   assign wrStrobe   = slvAck && hit && (op == opWrite);  // Commit in ack cycle
   assign statusWord = {{(`KS_WIDTH-1){1'b0}}, busy};

   ////////////////////////////////////////////////////////////////////////////
   // Slave handshake
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         slvAck  <= 1'b0;
         slvIdle <= 1'b0;
      end
      else if (slvAck)
      begin
         slvAck  <= 1'b0;
         slvIdle <= 1'b1;
      end
      else if (slvIdle)
         slvIdle <= 1'b0;
      else if (hit)
         slvAck <= 1'b1;                     // One cycle after the request
   end

   always_ff @(posedge clk)
   begin
      if (hit && !slvAck && !slvIdle)
      begin
         case (regSel)
            2'd0:    slvRdata <= dataReg;
            2'd1:    slvRdata <= dmaAddrReg;
            2'd2:    slvRdata <= statusWord;
            default: slvRdata <= '0;         // Unused offset
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Registers and DMA engine
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         dataReg    <= '0;
         dmaAddrReg <= '0;
         busy       <= 1'b0;
         state      <= ubaIdle;
      end
      else
      begin
         if (wrStrobe && (regSel == 2'd0))
            dataReg <= ubaData;
         case (state)
            ubaIdle:
               if (wrStrobe && (regSel == 2'd1))
               begin
                  dmaAddrReg <= ubaData;
                  busy       <= 1'b1;
                  state      <= ubaDma;      // Request goes out next cycle
               end
            ubaDma:
               if (dmaAck)
                  state <= ubaDone;
            ubaDone:
            begin
               busy  <= 1'b0;
               state <= ubaIdle;
            end
            default:
               state <= ubaIdle;
         endcase
      end
   end

   // Memory write at the DMA address
   always_comb
   begin
      dmaAddr                = dmaAddrReg;
      dmaAddr[`KS_WRITE_BIT] = 1'b1;
      dmaAddr[`KS_IO_BIT]    = 1'b0;
   end

   assign dmaReq   = (state == ubaDma);
   assign dmaWdata = dataReg;

endmodule

// ==== design/ksBus.sv ====
////////////////////////////////////////////////////////////////////////////
// Backplane top, CPU and console masters and the console slave are outside
// Adapters sit at Unibus numbers 1 and 3
////////////////////////////////////////////////////////////////////////////

module ksBus
   import ksBusPkg::*;
(
   input  logic    clk,
   input  logic    reset,
   // CPU master
   input  logic    cpuReq,
   output logic    cpuAck,
   input  ksWord_t cpuAddr,
   input  ksWord_t cpuWdata,
   output ksWord_t cpuRdata,
   // Console master
   input  logic    cslReqIn,
   output logic    cslAckOut,
   input  ksWord_t cslAddr,
   input  ksWord_t cslWdata,
   output ksWord_t cslRdata,         // Also write data into console space
   // Console slave
   output logic    cslReqOut,
   input  logic    cslAckIn,
   input  ksWord_t cslSlaveData,
   // Routed address, console decodes its own space
   output ksWord_t arbAddr
);

   // Memory side
   logic    memReq;
   logic    memAck;
   ksWord_t memRdata;
   ksWord_t memData;
   // Adapter slave side
   logic    ubaReq;
   ksWord_t ubaData;
   // Adapter 1
   logic    uba1Req;
   logic    uba1Ack;
   ksWord_t uba1Addr;
   ksWord_t uba1Wdata;
   logic    uba1SlvAck;
   ksWord_t uba1SlvRdata;
   // Adapter 3
   logic    uba3Req;
   logic    uba3Ack;
   ksWord_t uba3Addr;
   ksWord_t uba3Wdata;
   logic    uba3SlvAck;
   ksWord_t uba3SlvRdata;

   busArb uArb
   (
      .cpuReq       (cpuReq),
      .cpuAck       (cpuAck),
      .cpuAddr      (cpuAddr),
      .cpuWdata     (cpuWdata),
      .cpuRdata     (cpuRdata),
      .cslReqIn     (cslReqIn),
      .cslAckOut    (cslAckOut),
      .cslAddr      (cslAddr),
      .cslWdata     (cslWdata),
      .cslRdata     (cslRdata),
      .cslReqOut    (cslReqOut),
      .cslAckIn     (cslAckIn),
      .cslSlaveData (cslSlaveData),
      .uba1Req      (uba1Req),
      .uba1Ack      (uba1Ack),
      .uba1Addr     (uba1Addr),
      .uba1Wdata    (uba1Wdata),
      .uba1AckIn    (uba1SlvAck),
      .uba1Rdata    (uba1SlvRdata),
      .uba3Req      (uba3Req),
      .uba3Ack      (uba3Ack),
      .uba3Addr     (uba3Addr),
      .uba3Wdata    (uba3Wdata),
      .uba3AckIn    (uba3SlvAck),
      .uba3Rdata    (uba3SlvRdata),
      .ubaReq       (ubaReq),
      .ubaData      (ubaData),
      .memReq       (memReq),
      .memAck       (memAck),
      .memRdata     (memRdata),
      .memData      (memData),
      .arbAddr      (arbAddr)
   );

   memCtrl uMem
   (
      .clk      (clk),
      .reset    (reset),
      .memReq   (memReq),
      .arbAddr  (arbAddr),
      .memData  (memData),
      .memAck   (memAck),
      .memRdata (memRdata)
   );

   ubaBridge #(.ubaNum(1)) uba1
   (
      .clk      (clk),
      .reset    (reset),
      .ubaReq   (ubaReq),
      .arbAddr  (arbAddr),
      .ubaData  (ubaData),
      .slvAck   (uba1SlvAck),
      .slvRdata (uba1SlvRdata),
      .dmaReq   (uba1Req),
      .dmaAddr  (uba1Addr),
      .dmaWdata (uba1Wdata),
      .dmaAck   (uba1Ack)
   );

   ubaBridge #(.ubaNum(3)) uba3
   (
      .clk      (clk),
      .reset    (reset),
      .ubaReq   (ubaReq),
      .arbAddr  (arbAddr),
      .ubaData  (ubaData),
      .slvAck   (uba3SlvAck),
      .slvRdata (uba3SlvRdata),
      .dmaReq   (uba3Req),
      .dmaAddr  (uba3Addr),
      .dmaWdata (uba3Wdata),
      .dmaAck   (uba3Ack)
   );

endmodule

// ==== test/ksBus_checker.sv ====
////////////////////////////////////////////////////////////////////////////
// Bound into ksBus, samples the ACK levels on the rising edge
////////////////////////////////////////////////////////////////////////////

module ksBusChecker
(
   input logic clk,
   input logic reset,
   input logic cpuAck,
   input logic cslAckOut,
   input logic memAck
);

   int errCount = 0;                 // Assertion failures so far

   // Reset is synchronous, ACKs are low from the cycle after a reset edge
   ackLowInReset: assert property (@(posedge clk) reset |=> !(cpuAck || cslAckOut || memAck))
   else
   begin
      errCount++;
      $error("An ACK was high while reset was asserted");
   end

   // Only one master can hold the grant
   oneMasterAck: assert property (@(posedge clk) disable iff (reset) !(cpuAck && cslAckOut))
   else
   begin
      errCount++;
      $error("CPU and console ACK were high in the same cycle");
   end

   // Single cycle ack, recovery follows
   memAckPulse: assert property (@(posedge clk) disable iff (reset) memAck |=> !memAck)
   else
   begin
      errCount++;
      $error("Memory ACK stayed high for two cycles");
   end

endmodule

bind ksBus ksBusChecker uChecker
(
   .clk       (clk),
   .reset     (reset),
   .cpuAck    (cpuAck),
   .cslAckOut (cslAckOut),
   .memAck    (memAck)
);

// ==== test/ksBusMonitor.sv ====
////////////////////////////////////////////////////////////////////////////
// Samples ACKs on the falling edge, tests are framed by beginTest/endTest
////////////////////////////////////////////////////////////////////////////

module ksBusMonitor
   import ksBusPkg::*;
(
   input logic    clk,
   input logic    cpuAck,
   input ksWord_t cpuRdata,
   input logic    cslAckOut,
   input ksWord_t cslRdata,
   input logic    cslReqOut
);

   string   testName    = "";
   int      cycle       = 0;        // Falling edge count
   int      cpuAcks     = 0;
   int      cslAcks     = 0;
   int      cpuAckCycle = 0;
   int      cslAckCycle = 0;
   ksWord_t cpuData     = '0;       // Last acknowledged read data
   ksWord_t cslData     = '0;
   bit      reqOutSeen  = 1'b0;
   int      passCount   = 0;
   int      failCount   = 0;

   // Each ACK pulse spans exactly one falling edge
   always @(negedge clk)
   begin
      cycle++;
      if (cpuAck)
      begin
         cpuAcks++;
         cpuAckCycle = cycle;
         cpuData     = cpuRdata;
      end
      if (cslAckOut)
      begin
         cslAcks++;
         cslAckCycle = cycle;
         cslData     = cslRdata;
      end
      if (cslReqOut)
         reqOutSeen = 1'b1;
   end

   task automatic beginTest(input string name);
      testName   = name;
      cpuAcks    = 0;
      cslAcks    = 0;
      reqOutSeen = 1'b0;
   endtask

   function automatic bit compareWord(input string who, input ksWord_t expVal,
                                      input ksWord_t actual);
      if (expVal !== actual)
      begin
         $display("[FAIL] %s %s expected %h actual %h", testName, who, expVal, actual);
         return 1'b0;
      end
      return 1'b1;
   endfunction

   task automatic endTest(input string mode, input bit isRead, input ksWord_t expVal);
      bit ok;
      ok = 1'b1;
      case (mode)
         "idle":
            if ((cpuAcks != 0) || (cslAcks != 0) || reqOutSeen)
            begin
               $display("[FAIL] %s saw an ACK or a console request while idle", testName);
               ok = 1'b0;
            end
         "cpu", "poll":
            if ((cpuAcks == 0) || (cslAcks != 0) || ((mode == "cpu") && (cpuAcks != 1)))
            begin
               $display("[FAIL] %s got %0d CPU and %0d console ACKs", testName, cpuAcks,
                        cslAcks);
               ok = 1'b0;
            end
            else if (isRead)
               ok = compareWord("cpu", expVal, cpuData);
         "csl":
            if ((cslAcks != 1) || (cpuAcks != 0))
            begin
               $display("[FAIL] %s got %0d console and %0d CPU ACKs", testName, cslAcks,
                        cpuAcks);
               ok = 1'b0;
            end
            else if (isRead)
               ok = compareWord("csl", expVal, cslData);
         "both":
            if ((cslAcks != 1) || (cpuAcks != 1))
            begin
               $display("[FAIL] %s did not get one ACK per master", testName);
               ok = 1'b0;
            end
            else if (cslAckCycle >= cpuAckCycle)
            begin
               $display("[FAIL] %s console ACK in cycle %0d not before CPU ACK in cycle %0d",
                        testName, cslAckCycle, cpuAckCycle);
               ok = 1'b0;
            end
            else if (isRead)
               ok = compareWord("csl", expVal, cslData) & compareWord("cpu", ~expVal, cpuData);
         default:
         begin
            $display("[FAIL] %s has an unknown master %s", testName, mode);
            ok = 1'b0;
         end
      endcase
      if (ok)
      begin
         passCount++;
         $display("[PASS] %s", testName);
      end
      else
         failCount++;
   endtask

   task automatic printCounts(input int assertFails);
      $display("Summary: %0d tests, %0d passed, %0d failed, %0d assertion failures",
               passCount + failCount, passCount, failCount, assertFails);
   endtask

endmodule

// ==== test/ksBusTb.sv ====
////////////////////////////////////////////////////////////////////////////
// Run from the project root, vectors come from test/ksBus_vectors.txt
// Inputs change on the falling edge, each request held until its ACK
////////////////////////////////////////////////////////////////////////////

`include "ksBus_consts.svh"

module ksBusTb
   import ksBusPkg::*;
();

   localparam ksWord_t consoleId = 36'h0C5100D10;   // Console identification word
   localparam int      maxPoll   = 20;

   logic    clk;
   logic    reset;
   logic    cpuReq;
   logic    cpuAck;
   ksWord_t cpuAddr;
   ksWord_t cpuWdata;
   ksWord_t cpuRdata;
   logic    cslReqIn;
   logic    cslAckOut;
   ksWord_t cslAddr;
   ksWord_t cslWdata;
   ksWord_t cslRdata;
   logic    cslReqOut;
   logic    cslAckIn;
   ksWord_t cslSlaveData;
   ksWord_t arbAddr;

   // Vector table
   string   vecName [$];
   string   vecMode [$];
   ksWord_t vecAddr [$];
   ksWord_t vecWdata [$];
   ksWord_t vecExpect [$];
   bit      loaded = 1'b0;

   ksBus u_dut (.*);

   ksBusMonitor uMon
   (
      .clk       (clk),
      .cpuAck    (cpuAck),
      .cpuRdata  (cpuRdata),
      .cslAckOut (cslAckOut),
      .cslRdata  (cslRdata),
      .cslReqOut (cslReqOut)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Masters
   ////////////////////////////////////////////////////////////////////////////

   task automatic cpuCycle(input ksWord_t addr, input ksWord_t data, output ksWord_t rdata);
      @(negedge clk);
      cpuReq   <= 1'b1;
      cpuAddr  <= addr;
      cpuWdata <= data;
      do
         @(negedge clk);
      while (!cpuAck);                       // Level holds through the next rising edge
      rdata = cpuRdata;
      @(negedge clk);
      cpuReq   <= 1'b0;
      cpuAddr  <= '0;
      cpuWdata <= '0;
   endtask

   task automatic cslCycle(input ksWord_t addr, input ksWord_t data);
      @(negedge clk);
      cslReqIn <= 1'b1;
      cslAddr  <= addr;
      cslWdata <= data;
      do
         @(negedge clk);
      while (!cslAckOut);
      @(negedge clk);
      cslReqIn <= 1'b0;
      cslAddr  <= '0;
      cslWdata <= '0;
   endtask

   // Console slave, adapter field 0 in I/O space
   initial
   begin
      forever
      begin
         @(negedge clk);
         if (cslReqOut && arbAddr[`KS_IO_BIT] && (arbAddr[`KS_UBA_MSB:`KS_UBA_LSB] == '0))
         begin
            @(negedge clk);
            cslAckIn     <= 1'b1;
            cslSlaveData <= consoleId;
            @(negedge clk);
            cslAckIn     <= 1'b0;
            cslSlaveData <= '0;
            @(negedge clk);                  // Dead cycle while the CPU lets go
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      int      fd;
      int      polls;
      string   line;
      string   name;
      string   mode;
      ksWord_t addr;
      ksWord_t data;
      ksWord_t expVal;
      ksWord_t rdata;
      bit      isRead;
      reset        = 1'b1;
      cpuReq       = 1'b0;
      cpuAddr      = '0;
      cpuWdata     = '0;
      cslReqIn     = 1'b0;
      cslAddr      = '0;
      cslWdata     = '0;
      cslAckIn     = 1'b0;
      cslSlaveData = '0;
      fd = $fopen("test/ksBus_vectors.txt", "r");
      if (fd == 0)
         $display("Could not open the vector file test/ksBus_vectors.txt");
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            if (($fgets(line, fd) > 0) && (line.substr(0, 0) != "#")
                && ($sscanf(line, "%s %s %h %h %h", name, mode, addr, data, expVal) == 5))
            begin
               vecName.push_back(name);
               vecMode.push_back(mode);
               vecAddr.push_back(addr);
               vecWdata.push_back(data);
               vecExpect.push_back(expVal);
            end
         end
         $fclose(fd);
         loaded = 1'b1;
      end
      repeat (16) @(negedge clk);
      reset <= 1'b0;
      foreach (vecName[i])
      begin
         isRead = !vecAddr[i][`KS_WRITE_BIT];
         @(posedge clk);                     // Away from the sampling edge
         uMon.beginTest(vecName[i]);
         case (vecMode[i])
            "idle":
               repeat (4) @(negedge clk);
            "cpu":
               cpuCycle(vecAddr[i], vecWdata[i], rdata);
            "csl":
               cslCycle(vecAddr[i], vecWdata[i]);
            "both":
               fork
                  cslCycle(vecAddr[i], vecWdata[i]);
                  cpuCycle(vecAddr[i] + 1, ~vecWdata[i], rdata);
               join
            "poll":
            begin
               polls = 0;
               do
               begin
                  cpuCycle(vecAddr[i], vecWdata[i], rdata);
                  polls++;
               end
               while ((rdata !== vecExpect[i]) && (polls < maxPoll));
            end
            default:
               @(negedge clk);               // Monitor flags the bad mode
         endcase
         @(posedge clk);
         uMon.endTest(vecMode[i], isRead, vecExpect[i]);
      end
      @(posedge clk);
      uMon.printCounts(u_dut.uChecker.errCount);
      if ((vecName.size() > 0) && (uMon.failCount == 0) && (u_dut.uChecker.errCount == 0))
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

   // Hang guard, 200 cycles per vector line on top of reset
   initial
   begin
      longint limit;
      wait (loaded);
      limit = (16 + 200 * vecName.size()) * 10;
      #(limit);
      $display("Watchdog expired after %0d time units, the bus handshake is hung", limit);
      $display("Some tests failed");
      $finish;
   end

endmodule

// ==== ksBus.f ====
+incdir+common
common/ksBusPkg.sv
arb/busArb.sv
mem/memCtrl.sv
uba/ubaBridge.sv
design/ksBus.sv
test/ksBus_checker.sv
test/ksBusMonitor.sv
test/ksBusTb.sv

// ==== test/ksBus_vectors.txt ====
# name master addr wdata expect, values in hex, the address write bit selects read or write
# master: idle, cpu, csl, poll (CPU reads until expect), both (CPU at addr+1 with ~wdata)
resetIdle      idle 000000000 000000000 000000000
uba1DataRst    cpu  080040000 000000000 000000000
uba1DmaRst     cpu  080040001 000000000 000000000
uba1StatRst    cpu  080040002 000000000 000000000
uba3DataRst    cpu  0800C0000 000000000 000000000
uba3DmaRst     cpu  0800C0001 000000000 000000000
uba3StatRst    cpu  0800C0002 000000000 000000000
memUnwritten   cpu  000000077 000000000 000000000
memWrite       cpu  100000010 123456789 000000000
memReadBack    cpu  000000010 000000000 123456789
memWriteTop    cpu  1000003FF FFFFFFFFF 000000000
memReadTop     cpu  0000003FF 000000000 FFFFFFFFF
cslMemWrite    csl  100000020 0AAAAAAAA 000000000
cslMemRead     csl  000000020 000000000 0AAAAAAAA
prioWrite      both 100000040 555000111 000000000
prioCslRead    csl  000000040 000000000 555000111
prioCpuRead    cpu  000000041 000000000 AAAFFFEEE
prioRead       both 000000040 000000000 555000111
uba1DataWr     cpu  180040000 111111111 000000000
uba3DataWr     cpu  1800C0000 333333333 000000000
uba1DataRd     cpu  080040000 000000000 111111111
uba3DataRd     cpu  0800C0000 000000000 333333333
cslUba1Rd      csl  080040000 000000000 111111111
dmaData        cpu  180040000 0DEADBEEF 000000000
dmaStart       cpu  180040001 000000155 000000000
dmaPoll        poll 080040002 000000000 000000000
dmaMemRd       cpu  000000155 000000000 0DEADBEEF
uba1DmaAddrRd  cpu  080040001 000000000 000000155
dma3Data       cpu  1800C0000 0CAFE1234 000000000
dma3Start      cpu  1800C0001 000000266 000000000
dma3Poll       poll 0800C0002 000000000 000000000
dma3MemRd      cpu  000000266 000000000 0CAFE1234
cslSpaceRd     cpu  080000000 000000000 0C5100D10
